// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // address and data width of the core
    typedef logic [63:0] xlen_t;

    // one uncompressed instruction
    typedef logic [31:0] inst_t;

    // redirect request from the execute stage
    typedef struct packed {
        logic  jal;
        logic  branch;
        logic  jalr;
        logic  trap;
        xlen_t alu_res;
        xlen_t ex_pc;
        xlen_t imm;
        xlen_t rs1_data;
        xlen_t mtvec;
    } exec_redirect_t;

    // read address channel toward instruction memory
    typedef struct packed {
        logic  ar_valid;
        xlen_t ar_addr;
    } mem_req_t;

    // read data channel from instruction memory
    typedef struct packed {
        logic  r_valid;
        xlen_t r_data;
    } mem_rsp_t;

    // instruction handed to decode
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetch_out_t;

    // request FSM of fetch_ctrl
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_e;

endpackage

// ==== hw/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic                clk,
    input  logic                reset_i,

    // hold back new requests
    input  logic                stall_i,

    // pc the next delivery must carry
    input  fetch_pkg::xlen_t    pc_i,

    // read address channel
    output fetch_pkg::mem_req_t mem_req_o,
    input  logic                mem_ar_ready_i,

    // read data channel
    input  fetch_pkg::mem_rsp_t mem_rsp_i,
    output logic                mem_r_ready_o,

    // toward pc_next and inst_align
    output logic                advance_o,
    output logic                deliver_o,
    output fetch_pkg::xlen_t    fetch_addr_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;

    // address of the read in flight
    fetch_pkg::xlen_t req_addr_q;

    logic ar_fire;
    logic r_fire;
    logic addr_match;
    logic hit;

    // handshakes on both channels
    assign ar_fire = mem_req_o.ar_valid && mem_ar_ready_i;
    assign r_fire  = mem_rsp_i.r_valid && mem_r_ready_o;

    // a redirect since the request makes the response stale
    assign addr_match = (req_addr_q == pc_i);
    assign hit        = r_fire && addr_match;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                // stall only gates a new request
                if (!stall_i) begin
                    state_d = fetch_pkg::ADDR;
                end
            end
            fetch_pkg::ADDR: begin
                if (ar_fire) begin
                    state_d = fetch_pkg::DATA;
                end
            end
            fetch_pkg::DATA: begin
                // stale or not, go back and request the current pc
                if (r_fire) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: begin
                state_d = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture pc when leaving IDLE
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::IDLE && !stall_i) begin
            req_addr_q <= pc_i;
        end
    end

    // address held stable while ar_valid is up
    always_comb begin
        mem_req_o          = '0;
        mem_req_o.ar_valid = (state_q == fetch_pkg::ADDR);
        mem_req_o.ar_addr  = req_addr_q;
    end

    assign mem_r_ready_o = (state_q == fetch_pkg::DATA);

    // one cycle pulses on a matching response
    assign advance_o    = hit;
    assign deliver_o    = hit;
    assign fetch_addr_o = req_addr_q;

endmodule

// ==== hw/pc_next.sv ====
module pc_next #(
    parameter fetch_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic                      clk,
    input  logic                      reset_i,

    // strobes and operands from execute
    input  fetch_pkg::exec_redirect_t redirect_i,

    // matching response accepted this cycle
    input  logic                      advance_i,

    output fetch_pkg::xlen_t          pc_o
);

    fetch_pkg::xlen_t pc_q;
    fetch_pkg::xlen_t pc_d;

    // redirect targets
    fetch_pkg::xlen_t branch_target;
    fetch_pkg::xlen_t jalr_sum;
    fetch_pkg::xlen_t jalr_target;
    fetch_pkg::xlen_t seq_pc;

    logic branch_taken;

    // branch resolves taken when the alu result is zero
    assign branch_taken = redirect_i.branch && (redirect_i.alu_res == '0);

    // jal and branch share the pc relative target
    assign branch_target = redirect_i.ex_pc + redirect_i.imm;

    // jalr clears bit 0
    assign jalr_sum    = redirect_i.rs1_data + redirect_i.imm;
    assign jalr_target = {jalr_sum[63:1], 1'b0};

    assign seq_pc = pc_q + 64'd4;

    // redirect beats advance
    always_comb begin
        pc_d = pc_q;
        if (redirect_i.jal || branch_taken) begin
            pc_d = branch_target;
        end else if (redirect_i.jalr) begin
            pc_d = jalr_target;
        end else if (redirect_i.trap) begin
            pc_d = redirect_i.mtvec;
        end else if (advance_i) begin
            pc_d = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== hw/inst_align.sv ====
module inst_align (
    input  logic                  clk,
    input  logic                  reset_i,

    // response accepted and still matching pc
    input  logic                  deliver_i,

    // address the response belongs to
    input  fetch_pkg::xlen_t      fetch_addr_i,

    // aligned 64-bit word from memory
    input  fetch_pkg::xlen_t      rsp_data_i,

    output fetch_pkg::fetch_out_t fetch_o
);

    // selected 32-bit half
    fetch_pkg::inst_t inst_half;

    // address bit 2 picks the upper word
    assign inst_half = fetch_addr_i[2] ? rsp_data_i[63:32] : rsp_data_i[31:0];

    // valid for exactly one cycle, zeros otherwise
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_o <= '0;
        end else if (deliver_i) begin
            fetch_o.valid <= 1'b1;
            fetch_o.pc    <= fetch_addr_i;
            fetch_o.inst  <= inst_half;
        end else begin
            fetch_o <= '0;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit #(
    parameter fetch_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic                      clk,
    input  logic                      reset_i,

    // pipeline control
    input  logic                      stall_i,
    input  fetch_pkg::exec_redirect_t redirect_i,

    // instruction memory read channels
    output fetch_pkg::mem_req_t       mem_req_o,
    input  logic                      mem_ar_ready_i,
    input  fetch_pkg::mem_rsp_t       mem_rsp_i,
    output logic                      mem_r_ready_o,

    // toward decode
    output fetch_pkg::fetch_out_t     fetch_o
);

    // current program counter
    fetch_pkg::xlen_t pc;

    // accepted response matched pc
    logic advance;
    logic deliver;

    // address of the read that just returned
    fetch_pkg::xlen_t fetch_addr;

    // request FSM and stale response filter
    fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .pc_i           (pc),
        .mem_req_o      (mem_req_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_rsp_i      (mem_rsp_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .advance_o      (advance),
        .deliver_o      (deliver),
        .fetch_addr_o   (fetch_addr)
    );

    // pc register and redirect priority
    pc_next #(
        .RESET_PC (RESET_PC)
    ) u_pc_next (
        .clk        (clk),
        .reset_i    (reset_i),
        .redirect_i (redirect_i),
        .advance_i  (advance),
        .pc_o       (pc)
    );

    // half word select and output register
    inst_align u_inst_align (
        .clk          (clk),
        .reset_i      (reset_i),
        .deliver_i    (deliver),
        .fetch_addr_i (fetch_addr),
        .rsp_data_i   (mem_rsp_i.r_data),
        .fetch_o      (fetch_o)
    );

endmodule

// ==== sim/tb_fetch_unit.sv ====
module tb_fetch_unit;

    localparam fetch_pkg::xlen_t RESET_PC = 64'h8000_0000;
    localparam int NUM_DELIVERIES = 400;
    localparam int IDLE_LIMIT = 200;

    logic                      clk;
    logic                      reset_i;
    logic                      stall_i;
    fetch_pkg::exec_redirect_t redirect_i;
    fetch_pkg::mem_req_t       mem_req_o;
    logic                      mem_ar_ready_i;
    fetch_pkg::mem_rsp_t       mem_rsp_i;
    logic                      mem_r_ready_o;
    fetch_pkg::fetch_out_t     fetch_o;

    logic [31:0] lfsr_q;

    // reference model state
    fetch_pkg::fetch_state_e model_state;
    fetch_pkg::xlen_t        model_pc;
    fetch_pkg::xlen_t        model_req_addr;
    logic                    expect_valid;
    fetch_pkg::xlen_t        expect_pc;
    fetch_pkg::inst_t        expect_inst;

    // memory responder
    logic             rsp_pending;
    logic [1:0]       rsp_wait;
    fetch_pkg::xlen_t rsp_addr;

    int deliveries;
    int idle_cycles;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .redirect_i     (redirect_i),
        .mem_req_o      (mem_req_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_rsp_i      (mem_rsp_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .fetch_o        (fetch_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // each 32-bit half holds its own address xor a marker
    // upper address bits are folded into both halves
    function automatic fetch_pkg::xlen_t mem_word(input fetch_pkg::xlen_t addr);
        logic [31:0] base;
        logic [31:0] upper;
        base  = {addr[31:3], 3'b000};
        upper = addr[63:32];
        return {(base + 32'd4) ^ upper ^ 32'h5a5a_0000, base ^ upper ^ 32'h5a5a_0000};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic drive_inputs();
        logic [3:0] strobes;
        mem_ar_ready_i = (rand_bits(2) != 32'd0);
        stall_i = (rand_bits(3) == 32'd0);

        // strobes last a single cycle
        redirect_i = '0;
        if (deliveries > 0 && rand_bits(8) < 32'd21) begin
            strobes = 4'(rand_bits(4));
            if (strobes == 4'd0) begin
                strobes = 4'b0100;
            end
            redirect_i.jal    = strobes[3];
            redirect_i.branch = strobes[2];
            redirect_i.jalr   = strobes[1];
            redirect_i.trap   = strobes[0];
            if (rand_bits(1) == 32'd1) begin
                redirect_i.alu_res = '0;
            end else begin
                redirect_i.alu_res = 64'(rand_bits(16)) | 64'd1;
            end
            redirect_i.ex_pc    = RESET_PC + (64'(rand_bits(12)) << 2);
            redirect_i.imm      = 64'(rand_bits(10)) << 2;
            // odd so that the jalr bit clear is exercised
            redirect_i.rs1_data = RESET_PC + (64'(rand_bits(12)) << 2) + 64'd1;
            redirect_i.mtvec    = RESET_PC + 64'h1000 + (64'(rand_bits(8)) << 2);
        end

        // responder raises r_valid after its delay and holds it until taken
        if (rsp_pending) begin
            if (!mem_rsp_i.r_valid) begin
                if (rsp_wait == 2'd0) begin
                    mem_rsp_i.r_valid = 1'b1;
                    mem_rsp_i.r_data  = mem_word(rsp_addr);
                end else begin
                    rsp_wait = rsp_wait - 2'd1;
                end
            end
        end else begin
            mem_rsp_i = '0;
        end
    endtask

    task automatic observe_cycle();
        logic ar_fire;
        logic r_fire;
        logic hit;

        check_value("mem_req_o.ar_valid", 64'(mem_req_o.ar_valid),
                    64'(model_state == fetch_pkg::ADDR));
        check_value("mem_r_ready_o", 64'(mem_r_ready_o),
                    64'(model_state == fetch_pkg::DATA));
        if (mem_req_o.ar_valid) begin
            check_value("mem_req_o.ar_addr", mem_req_o.ar_addr, model_req_addr);
        end

        // delivery one cycle after a matching acceptance and zeros otherwise
        if (expect_valid) begin
            check_value("fetch_o.valid", 64'(fetch_o.valid), 64'd1);
            check_value("fetch_o.pc", fetch_o.pc, expect_pc);
            check_value("fetch_o.inst", 64'(fetch_o.inst), 64'(expect_inst));
            deliveries++;
            idle_cycles = 0;
        end else begin
            check_value("fetch_o.valid", 64'(fetch_o.valid), 64'd0);
            check_value("fetch_o.pc", fetch_o.pc, 64'd0);
            check_value("fetch_o.inst", 64'(fetch_o.inst), 64'd0);
        end

        ar_fire = mem_req_o.ar_valid && mem_ar_ready_i;
        r_fire  = mem_rsp_i.r_valid && mem_r_ready_o;
        hit     = r_fire && (model_req_addr == model_pc);

        expect_valid = hit;
        expect_pc    = model_req_addr;
        expect_inst  = model_req_addr[31:0] ^ model_req_addr[63:32] ^ 32'h5a5a_0000;

        if (ar_fire) begin
            rsp_pending = 1'b1;
            rsp_wait    = 2'(rand_bits(2));
            rsp_addr    = mem_req_o.ar_addr;
        end
        if (r_fire) begin
            rsp_pending = 1'b0;
        end

        // request address is the pc seen when leaving IDLE
        case (model_state)
            fetch_pkg::IDLE: begin
                if (!stall_i) begin
                    model_state    = fetch_pkg::ADDR;
                    model_req_addr = model_pc;
                end
            end
            fetch_pkg::ADDR: begin
                if (ar_fire) begin
                    model_state = fetch_pkg::DATA;
                end
            end
            default: begin
                if (r_fire) begin
                    model_state = fetch_pkg::IDLE;
                end
            end
        endcase

        // redirect priority before the sequential step
        if (redirect_i.jal || (redirect_i.branch && redirect_i.alu_res == 64'd0)) begin
            model_pc = redirect_i.ex_pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            model_pc = (redirect_i.rs1_data + redirect_i.imm) & ~64'd1;
        end else if (redirect_i.trap) begin
            model_pc = redirect_i.mtvec;
        end else if (hit) begin
            model_pc = model_pc + 64'd4;
        end
    endtask

    initial begin
        lfsr_q         = 32'h76f0cd15;
        reset_i        = 1'b1;
        stall_i        = 1'b0;
        redirect_i     = '0;
        mem_ar_ready_i = 1'b0;
        mem_rsp_i      = '0;

        model_state    = fetch_pkg::IDLE;
        model_pc       = RESET_PC;
        model_req_addr = '0;
        expect_valid   = 1'b0;
        expect_pc      = '0;
        expect_inst    = '0;
        rsp_pending    = 1'b0;
        rsp_wait       = 2'd0;
        rsp_addr       = '0;
        deliveries     = 0;
        idle_cycles    = 0;

        // outputs stay quiet in reset
        repeat (9) begin
            @(posedge clk);
            #4;
            check_value("mem_req_o.ar_valid", 64'(mem_req_o.ar_valid), 64'd0);
            check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'd0);
            check_value("fetch_o.valid", 64'(fetch_o.valid), 64'd0);
        end
        @(posedge clk);
        #1;
        reset_i = 1'b0;

        while (deliveries < NUM_DELIVERIES) begin
            drive_inputs();
            #3;
            observe_cycle();
            @(posedge clk);
            #1;
            idle_cycles++;
            if (idle_cycles > IDLE_LIMIT) begin
                $display("timeout: no instruction delivered within %0d cycles", IDLE_LIMIT);
                $display("Some tests failed");
                $fatal(1, "fetch unit stopped delivering");
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== fetch_unit.f ====
common/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/pc_next.sv
hw/inst_align.sv
hw/fetch_unit.sv
sim/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch unit testbench with Verilator.
# The pass message in the log decides the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fetch_unit \
    -f fetch_unit.f -o sim_fetch_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
